/* verilog.f */
rtl/bitscan_pkg.sv
rtl/lzc.sv
rtl/bitscan_combine.sv
rtl/bitscan_axil_regs.sv
rtl/bitscan_top.sv
tb/bitscan_assertions.sv
tb/bitscan_checker.sv
tb/tb_bitscan.sv

/* tb/bitscan_stimulus.txt */
# test name, operand in hex, expected result word in hex
# result word holds span in 29..24, empty in 16, leading count in 12..8, trailing in 4..0
single_bit0   00000001 01001F00
single_bit31  80000000 0100001F
single_bit5   00000020 01001A05
single_bit16  00010000 01000F10
zero_operand  00000000 00010000
both_ends     80000001 20000000
all_ones      FFFFFFFF 20000000
mid_block     00F00F00 10000808
adjacent_pair 00018000 02000F0F
mixed_1234    12345678 1A000303
mixed_a5a4    A5A5A5A4 1E000002
single_bit10  00000400 0100150A

/* tb/tb_bitscan.sv */
// ============================
// Testbench for the bit-scan peripheral
// Writes each stimulus operand over AXI4-Lite and reads back result and operand
// ============================

`timescale 1ns/10ps

module tb_bitscan
  import bitscan_pkg::*;
();

  // DUT port signals, each named as the port it connects to
  logic                  clk_i;
  logic                  rst_n_i;
  logic [ADDR_WIDTH-1:0] awaddr_i, araddr_i;
  logic [DATA_WIDTH-1:0] wdata_i, rdata_o;
  logic [STRB_WIDTH-1:0] wstrb_i;
  logic [1:0]            bresp_o, rresp_o;
  logic                  awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
  logic                  arvalid_i, arready_o, rvalid_o, rready_i;

  // Expected values that the checker compares against
  string                 test_name;
  logic [DATA_WIDTH-1:0] exp_rdata;
  logic [1:0]            exp_rresp;
  logic [1:0]            exp_bresp;

  // Stimulus file state
  int                    fd;
  string                 line;
  // Name read from the file, handed to the checker once the edge has passed
  string                 next_name;
  logic [DATA_WIDTH-1:0] operand;
  logic [DATA_WIDTH-1:0] exp_word;
  logic [DATA_WIDTH-1:0] last_word;
  int                    num_tests = 0;

  int timeouts     = 0;
  int other_errs   = 0;
  int reads_issued = 0;
  int total_errs;
  // Longest wait for one handshake, in clock edges
  int wait_limit   = 100;

  bitscan_top u_bitscan_top (.*);

  bitscan_checker u_checker ();

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Channel 0 is AW with W, then B, AR and R
  task automatic await_transfer(input int chan, input string what);
    int tries;
    bit fired;
    tries = 0;
    do begin
      @(posedge clk_i);
      tries++;
      case (chan)
        0:       fired = awready_o && wready_o;
        1:       fired = bvalid_o && bready_i;
        2:       fired = arready_o;
        default: fired = rvalid_o && rready_i;
      endcase
    end while (!fired && tries < wait_limit);
    if (!fired) begin
      $display("timeout: no %s transfer in test %s", what, test_name);
      timeouts++;
    end
  endtask

  // One AXI4-Lite access with its response ready held back for stall cycles
  task automatic access(input bit wr, input logic [ADDR_WIDTH-1:0] addr,
                        input logic [DATA_WIDTH-1:0] data, input logic [1:0] resp,
                        input int stall);
    if (wr) begin
      awaddr_i  <= addr;
      wdata_i   <= data;
      awvalid_i <= 1'b1;
      wvalid_i  <= 1'b1;
      exp_bresp <= resp;
      await_transfer(0, "write request");
    end else begin
      araddr_i  <= addr;
      arvalid_i <= 1'b1;
      exp_rdata <= data;
      exp_rresp <= resp;
      reads_issued++;
      await_transfer(2, "read request");
    end
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    arvalid_i <= 1'b0;
    repeat (stall) @(posedge clk_i);
    bready_i <= wr;
    rready_i <= !wr;
    await_transfer(wr ? 1 : 3, "response");
    bready_i <= 1'b0;
    rready_i <= 1'b0;
  endtask

  initial begin
    // All DUT inputs idle with reset held
    rst_n_i   = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '1;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    // Before any write the result is the empty word with only the flag set
    test_name = "after_reset";
    access(1'b0, ADDR_RESULT, 32'h0001_0000, RESP_OKAY, 0);

    fd = $fopen("tb/bitscan_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file tb/bitscan_stimulus.txt");
      other_errs++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Lines starting with # hold comments
        if (line.len() > 1 && line[0] != "#" &&
            $sscanf(line, "%s %h %h", next_name, operand, exp_word) == 3) begin
          // The previous read may still be checked on this edge
          test_name <= next_name;
          // Every second test stalls both responses for a few cycles
          access(1'b1, ADDR_OPERAND, operand, RESP_OKAY, (num_tests % 2) * 4);
          access(1'b0, ADDR_RESULT, exp_word, RESP_OKAY, (num_tests % 2) * 4);
          access(1'b0, ADDR_OPERAND, operand, RESP_OKAY, 0);
          last_word = exp_word;
          num_tests++;
        end
      end
      $fclose(fd);
    end
    if (num_tests == 0) begin
      $display("no test lines were found in the stimulus file");
      other_errs++;
    end

    // The result register refuses a write and keeps its value
    test_name <= "write_result";
    access(1'b1, ADDR_RESULT, 32'hFFFF_FFFF, RESP_SLVERR, 3);
    access(1'b0, ADDR_RESULT, last_word, RESP_OKAY, 0);
    // An unmapped read answers with zero data
    test_name <= "unmapped_read";
    access(1'b0, 4'h8, '0, RESP_SLVERR, 3);

    // One more edge so the checker has counted the last read
    @(posedge clk_i);
    if (u_checker.reads_seen != reads_issued) begin
      $display("%0d reads were issued but the checker saw %0d",
               reads_issued, u_checker.reads_seen);
      other_errs++;
    end
    total_errs = u_checker.data_errs + u_checker.resp_errs + timeouts + other_errs
               + u_bitscan_top.u_regs.u_assertions.fail_cnt;
    $display("errors: data %0d, response %0d, timeout %0d, assertion %0d, other %0d",
             u_checker.data_errs, u_checker.resp_errs, timeouts,
             u_bitscan_top.u_regs.u_assertions.fail_cnt, other_errs);
    if (total_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* tb/bitscan_checker.sv */
// ============================
// Monitor of the AXI4-Lite responses of the DUT
// Compares every B and R transfer with the expected values in the testbench
// ============================

`timescale 1ns/10ps

module bitscan_checker;

  // Counts that the testbench sums up in its closing line
  int data_errs  = 0;
  int resp_errs  = 0;
  int reads_seen = 0;

  // Responses are sampled on the edge where they transfer
  always @(posedge tb_bitscan.clk_i) begin
    if (tb_bitscan.rvalid_o && tb_bitscan.rready_i) begin
      reads_seen++;
      if (tb_bitscan.rdata_o !== tb_bitscan.exp_rdata) begin
        $display("ERR %s: rdata expected %h actual %h", tb_bitscan.test_name,
                 tb_bitscan.exp_rdata, tb_bitscan.rdata_o);
        data_errs++;
      end
      if (tb_bitscan.rresp_o !== tb_bitscan.exp_rresp) begin
        $display("ERR %s: rresp expected %b actual %b", tb_bitscan.test_name,
                 tb_bitscan.exp_rresp, tb_bitscan.rresp_o);
        resp_errs++;
      end
    end
    // A write response carries only its code
    if (tb_bitscan.bvalid_o && tb_bitscan.bready_i &&
        tb_bitscan.bresp_o !== tb_bitscan.exp_bresp) begin
      $display("ERR %s: bresp expected %b actual %b", tb_bitscan.test_name,
               tb_bitscan.exp_bresp, tb_bitscan.bresp_o);
      resp_errs++;
    end
  end

endmodule

/* tb/bitscan_assertions.sv */
// ============================
// Handshake assertions bound into the AXI4-Lite register block
// ============================

`timescale 1ns/10ps

module bitscan_assertions
  import bitscan_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  bvalid_i,
  input logic                  bready_i,
  input logic [1:0]            bresp_i,
  input logic                  rvalid_i,
  input logic                  rready_i,
  input logic [DATA_WIDTH-1:0] rdata_i,
  input logic [1:0]            rresp_i
);

  // Failed checks so far, summed up by the testbench at the end
  int fail_cnt = 0;

  // A write response keeps valid and its code until bready takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("bvalid dropped or bresp changed before bready was high");
      fail_cnt++;
    end

  // A read response keeps valid, data and code until rready takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   rvalid_i && !rready_i |=>
                   rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      $error("rvalid dropped or rdata or rresp changed before rready was high");
      fail_cnt++;
    end

  // No response is pending right after a reset edge
  assert property (@(posedge clk_i) !rst_n_i |=> !bvalid_i && !rvalid_i)
    else begin
      $error("bvalid or rvalid high after reset");
      fail_cnt++;
    end

endmodule

// Clock, reset and both ready inputs connect by name
bind bitscan_axil_regs bitscan_assertions u_assertions (
  .*,
  .bvalid_i (bvalid_o),
  .bresp_i  (bresp_o),
  .rvalid_i (rvalid_o),
  .rdata_i  (rdata_o),
  .rresp_i  (rresp_o)
);

/* rtl/bitscan_top.sv */
// ============================
// Bit-scan peripheral top level with an AXI4-Lite slave port
// ============================

`timescale 1ns/10ps

module bitscan_top
  import bitscan_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  logic [ADDR_WIDTH-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,

  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [STRB_WIDTH-1:0] wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,

  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,

  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,

  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i
);

  // Operand from the register block to both counters
  logic [DATA_WIDTH-1:0] operand;
  // Counts on their way to the combiner
  logic [CNT_WIDTH-1:0]  tz_cnt;
  logic [CNT_WIDTH-1:0]  lz_cnt;
  logic                  tz_empty;
  // Registered result word back to the register block
  logic [DATA_WIDTH-1:0] result;

  bitscan_axil_regs u_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .operand_o (operand),
    .result_i  (result)
  );

  // Counts zeros below the lowest one bit
  lzc #(.WIDTH(DATA_WIDTH), .MODE(1'b0)) u_lzc_trail (
    .in_i    (operand),
    .cnt_o   (tz_cnt),
    .empty_o (tz_empty)
  );

  // Counts zeros above the highest one bit
  // Its empty flag always equals the trailing one and stays open
  lzc #(.WIDTH(DATA_WIDTH), .MODE(1'b1)) u_lzc_lead (
    .in_i    (operand),
    .cnt_o   (lz_cnt),
    .empty_o ()
  );

  bitscan_combine u_combine (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .tz_cnt_i   (tz_cnt),
    .lz_cnt_i   (lz_cnt),
    .tz_empty_i (tz_empty),
    .result_o   (result)
  );

endmodule

/* rtl/bitscan_axil_regs.sv */
// ============================
// AXI4-Lite slave with the operand and result registers
// One write and one read may be outstanding at a time
// ============================

`timescale 1ns/10ps

module bitscan_axil_regs
  import bitscan_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Write address channel
  input  logic [ADDR_WIDTH-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,

  // Write data channel
  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [STRB_WIDTH-1:0] wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,

  // Write response channel
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,

  // Read address channel
  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,

  // Read data channel
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,

  // Towards the zero counters and back from the combiner
  output logic [DATA_WIDTH-1:0] operand_o,
  input  logic [DATA_WIDTH-1:0] result_i
);

  // Operand register seen by both counters
  logic [DATA_WIDTH-1:0] operand_q;

  // Write response state and payload
  logic                  bvalid_q;
  logic [1:0]            bresp_q;

  // Read response state and payload
  logic                  rvalid_q;
  logic [DATA_WIDTH-1:0] rdata_q;
  logic [1:0]            rresp_q;

  // Transfer strobes for the address and data channels
  logic                  wr_fire;
  logic                  rd_fire;

  // Write decode
  logic                  wr_to_operand;
  logic                  wr_load;
  logic [1:0]            wr_resp_d;

  // Read decode
  logic [DATA_WIDTH-1:0] rd_data_d;
  logic [1:0]            rd_resp_d;

  // AW and W are taken together, and only while no write response waits
  assign wr_fire   = awvalid_i & wvalid_i & ~bvalid_q;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;

  // A read address is taken whenever no read response waits
  assign rd_fire   = arvalid_i & ~rvalid_q;
  assign arready_o = ~rvalid_q;

  assign wr_to_operand = (awaddr_i == ADDR_OPERAND);

  // Only a full-word write changes the operand
  // A partial strobe is still answered with OKAY but leaves the register alone
  assign wr_load = wr_fire & wr_to_operand & (&wstrb_i);

  // The result register and unmapped addresses refuse writes
  assign wr_resp_d = wr_to_operand ? RESP_OKAY : RESP_SLVERR;

  always_comb begin
    case (araddr_i)
      ADDR_OPERAND: begin
        rd_data_d = operand_q;
        rd_resp_d = RESP_OKAY;
      end
      ADDR_RESULT: begin
        rd_data_d = result_i;
        rd_resp_d = RESP_OKAY;
      end
      default: begin
        // Unmapped reads return zero with an error
        rd_data_d = '0;
        rd_resp_d = RESP_SLVERR;
      end
    endcase
  end

  // Control state and the operand
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      operand_q <= '0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // The operand loads on the same edge as the write transfer
      if (wr_load) begin
        operand_q <= wdata_i;
      end

      // bvalid rises with the write transfer and holds until bready
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end

      // rvalid rises with the read address transfer and holds until rready
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payloads only change on a new transfer
  // so they stay stable while the master stalls
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= wr_resp_d;
    end
    if (rd_fire) begin
      rdata_q <= rd_data_d;
      rresp_q <= rd_resp_d;
    end
  end

  assign operand_o = operand_q;

  assign bvalid_o  = bvalid_q;
  assign bresp_o   = bresp_q;

  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rresp_o   = rresp_q;

endmodule

/* rtl/bitscan_combine.sv */
// ============================
// Packs both zero counts into the registered result word
// Adds the empty flag and the span of significant bits
// ============================

`timescale 1ns/10ps

module bitscan_combine
  import bitscan_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [CNT_WIDTH-1:0]  tz_cnt_i,
  input  logic [CNT_WIDTH-1:0]  lz_cnt_i,
  input  logic                  tz_empty_i,
  output logic [DATA_WIDTH-1:0] result_o
);

  // Span from the lowest to the highest one bit, inclusive
  logic [SPAN_WIDTH-1:0] span;

  // Result word as it will be stored on the next edge
  logic [DATA_WIDTH-1:0] result_d;
  logic [DATA_WIDTH-1:0] result_q;

  // Both counts are zero extended to the span width before subtracting
  // With one bit at each end the span reaches DATA_WIDTH, hence the extra bit
  assign span = SPAN_WIDTH'(DATA_WIDTH)
              - {1'b0, tz_cnt_i}
              - {1'b0, lz_cnt_i};

  always_comb begin
    // Unused bits of the word read as zero
    result_d = '0;
    if (tz_empty_i) begin
      // No one bit in the operand
      // Both counters report 31 here, so the fields are left at zero
      // and only the flag is raised
      result_d[RES_EMPTY_BIT] = 1'b1;
    end else begin
      result_d[RES_TZ_LSB +: CNT_WIDTH]    = tz_cnt_i;
      result_d[RES_LZ_LSB +: CNT_WIDTH]    = lz_cnt_i;
      result_d[RES_SPAN_LSB +: SPAN_WIDTH] = span;
    end
  end

  // Single register stage
  // Each new operand replaces the previous result one edge later
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // After reset the operand is zero, so the word starts as the empty result
      result_q                <= '0;
      result_q[RES_EMPTY_BIT] <= 1'b1;
    end else begin
      result_q <= result_d;
    end
  end

  assign result_o = result_q;

endmodule

/* rtl/lzc.sv */
// ============================
// Leading or trailing zero counter as a combinational binary tree
// MODE 0 counts from bit 0, MODE 1 counts from the top bit
// ============================

`timescale 1ns/10ps

module lzc #(
  // Number of input bits to scan
  parameter int unsigned WIDTH = 2,
  // Scan direction, 0 counts trailing zeros and 1 counts leading zeros
  parameter bit          MODE  = 1'b0,
  // Count width follows from WIDTH and is never set from outside
  localparam int unsigned CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0] in_i,
  output logic [CNT_W-1:0] cnt_o,
  output logic             empty_o
);

  if (WIDTH == 1) begin : gen_single_bit

    // A lone bit has no zeros in front of it when set
    // When clear the count is width minus one, which is zero here
    assign cnt_o   = '0;
    assign empty_o = ~in_i[0];

  end else begin : gen_tree

    // Tree depth and the number of leaves after padding to a power of two
    localparam int unsigned NUM_LEVELS = $clog2(WIDTH);
    localparam int unsigned NUM_LEAVES = 2 ** NUM_LEVELS;

    // Vector that the tree searches, always starting from bit 0
    logic [WIDTH-1:0] scan_vec;

    // Tree nodes kept in heap order
    // Node n has its children at 2n+1 (lower bits) and 2n+2 (upper bits)
    // Leaf k sits at index NUM_LEAVES-1+k
    logic [2*NUM_LEAVES-2:0]            sel_nodes;
    logic [2*NUM_LEAVES-2:0][CNT_W-1:0] idx_nodes;

    if (MODE) begin : gen_mirror
      // Leading zero mode reverses the bit order
      // so the search from bit 0 finds the highest one bit
      for (genvar i = 0; i < WIDTH; i++) begin : gen_bit
        assign scan_vec[i] = in_i[WIDTH-1-i];
      end
    end else begin : gen_direct
      // Trailing zero mode searches the input as it is
      assign scan_vec = in_i;
    end

    // Leaves carry one input bit and its own position
    for (genvar k = 0; k < NUM_LEAVES; k++) begin : gen_leaf
      if (k < WIDTH) begin : gen_used
        assign sel_nodes[NUM_LEAVES-1+k] = scan_vec[k];
      end else begin : gen_pad
        // Padding leaves never hold a one bit
        assign sel_nodes[NUM_LEAVES-1+k] = 1'b0;
      end
      assign idx_nodes[NUM_LEAVES-1+k] = CNT_W'(k);
    end

    // Inner nodes report whether their subtree holds a one bit
    // and pass up the lowest position that does
    for (genvar n = 0; n < NUM_LEAVES - 1; n++) begin : gen_node
      assign sel_nodes[n] = sel_nodes[2*n+1] | sel_nodes[2*n+2];
      // The lower child wins when it holds a one, else the upper child is taken
      assign idx_nodes[n] = sel_nodes[2*n+1] ? idx_nodes[2*n+1] : idx_nodes[2*n+2];
    end

    // Root of the tree gives the result
    // An empty input reports width minus one, also for widths that needed padding
    assign cnt_o   = sel_nodes[0] ? idx_nodes[0] : CNT_W'(WIDTH - 1);
    assign empty_o = ~sel_nodes[0];

  end

endmodule

/* rtl/bitscan_pkg.sv */
// ============================
// Shared constants of the bit-scan peripheral
// Import with bitscan_pkg::* in a module header
// ============================

package bitscan_pkg;

  // Operand width and the width of one zero count
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned CNT_WIDTH  = $clog2(DATA_WIDTH);

  // One write strobe per byte of the operand
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // The span reaches DATA_WIDTH itself, so it needs one bit more than a count
  localparam int unsigned SPAN_WIDTH = CNT_WIDTH + 1;

  // AXI4-Lite address width, enough for the two word registers
  localparam int unsigned ADDR_WIDTH = 4;

  // Register map
  // The operand register is read/write
  localparam logic [ADDR_WIDTH-1:0] ADDR_OPERAND = 4'h0;
  // The result register is read-only, a write to it answers with an error
  localparam logic [ADDR_WIDTH-1:0] ADDR_RESULT  = 4'h4;

  // Field positions in the result word
  // Trailing count sits in bits 4 to 0
  localparam int unsigned RES_TZ_LSB    = 0;
  // Leading count sits in bits 12 to 8
  localparam int unsigned RES_LZ_LSB    = 8;
  // Set when the operand holds no one bit
  localparam int unsigned RES_EMPTY_BIT = 16;
  // Span of significant bits sits in bits 29 to 24
  localparam int unsigned RES_SPAN_LSB  = 24;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
